// File: fetchStage.f
src/fetchPkg.sv
src/cla16.sv
src/instrMem.sv
src/hazardDetect.sv
src/fetchStage.sv
verification/fetchStageTb.sv

// File: Bender.yml
package:
  name: fetchStage

sources:
  - src/fetchPkg.sv
  - src/cla16.sv
  - src/instrMem.sv
  - src/hazardDetect.sv
  - src/fetchStage.sv
  - target: test
    files:
      - verification/fetchStageTb.sv

// File: verification/fetchStageTb.sv
/*
   Testbench for the fetch stage with a cycle model of the PC.
   The program is loaded with reset held, then reset stays low three more cycles.
   Stage reports are random and not tied to the words that were issued.
   Outputs are checked on the falling edge, just before new inputs are driven.
*/
`timescale 1ns/100ps
`default_nettype none

module fetchStageTb import fetchPkg::*; ();

   localparam int nWords  = 2**memDepthLog2;
   localparam int nSeq    = 64;
   localparam int nHazard = 200;
   localparam int nCtrl   = 300;
   localparam int nDump   = 16;
   localparam int nWrap   = 6;
   localparam int totalCycles = nWords + nSeq + nHazard + nCtrl + nDump + nWrap + 24;
   localparam int watchdogNs  = totalCycles * 100 * 3 / 2;

   localparam stageInfoT idle     = '0;
   localparam stageInfoT redirect = '{regWrt: 1'b0, wrtReg: 3'd0, branchInst: 1'b1};

   logic      clk;
   logic      rstN;
   logic      createDump;
   addrT      newPC;
   stageInfoT stageD;
   stageInfoT stageX;
   stageInfoT stageM;
   stageInfoT stageW;
   logic      progEn;
   addrT      progAddr;
   wordT      progData;
   wordT      instruction;
   addrT      incPC;
   logic      instrValid;
   logic      branchInstF;
   logic      err;

   wordT prog [nWords];   // Copy of the loaded program.
   addrT modelPc;
   int   checks;
   int   errors;

   fetchStage u_fetchStage (
      .clk         (clk),
      .rstN        (rstN),
      .createDump  (createDump),
      .newPC       (newPC),
      .stageD      (stageD),
      .stageX      (stageX),
      .stageM      (stageM),
      .stageW      (stageW),
      .progEn      (progEn),
      .progAddr    (progAddr),
      .progData    (progData),
      .instruction (instruction),
      .incPC       (incPC),
      .instrValid  (instrValid),
      .branchInstF (branchInstF),
      .err         (err)
   );

   always #50 clk = ~clk;

   initial begin
      #(watchdogNs);
      $display("timeout: run did not finish within %0d ns", watchdogNs);
      $display("Simulation finished: FAIL");
      $finish;
   end

   task automatic checkWord(input string name, input wordT got, input wordT exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
      end
   endtask

   task automatic checkAddr(input string name, input addrT got, input addrT exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
      end
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
      end
   endtask

   // Opcode rules of the ISA, bits 15 to 11.
   function automatic logic usesRs(input wordT w);
      logic [4:0] op;
      op = w[15:11];
      return !(op == 5'b00000 || op == 5'b00001 || op == 5'b00100 || op == 5'b00110);
   endfunction

   function automatic logic usesRt(input wordT w);
      logic [4:0] op;
      op = w[15:11];
      return op == 5'b11011 || op == 5'b11111 || op == 5'b10000 || op == 5'b10011;
   endfunction

   function automatic logic isTransfer(input wordT w);
      return w[15:13] == 3'b001 || w[15:13] == 3'b011;
   endfunction

   function automatic logic stageWrites(input stageInfoT s, input wordT w);
      logic rsHit;
      logic rtHit;
      rsHit = usesRs(w) && (s.wrtReg == w[10:8]);
      rtHit = usesRt(w) && (s.wrtReg == w[7:5]);
      return s.regWrt && (rsHit || rtHit);
   endfunction

   // Writeback never stalls fetch.
   function automatic logic expectBubble(input wordT w);
      logic inFlight;
      inFlight = stageD.branchInst || stageX.branchInst || stageM.branchInst;
      return inFlight || stageWrites(stageD, w) || stageWrites(stageX, w)
         || stageWrites(stageM, w);
   endfunction

   function automatic stageInfoT randomStage(input int wrtPct, input int brPct);
      stageInfoT s;
      s.regWrt     = ($urandom % 100) < wrtPct;
      s.wrtReg     = regIdT'($urandom);
      s.branchInst = ($urandom % 100) < brPct;
      return s;
   endfunction

   function automatic addrT randomEven();
      return addrT'($urandom) & 16'hfffe;
   endfunction

   task automatic checkOutputs();
      wordT raw;
      logic bub;
      raw = prog[modelPc[memDepthLog2:1]];
      bub = !rstN || expectBubble(raw);
      checkWord("instruction", instruction, bub ? nopInstr : raw);
      checkAddr("incPC", incPC, modelPc + 16'd2);
      checkFlag("instrValid", instrValid, !bub);
      checkFlag("branchInstF", branchInstF, !bub && isTransfer(raw));
      checkFlag("err", err, modelPc == 16'hfffe);
   endtask

   // Next PC as the DUT takes it on the coming rising edge.
   task automatic stepModel();
      wordT raw;
      raw = prog[modelPc[memDepthLog2:1]];
      if (!rstN) begin
         modelPc = '0;
      end else if (!createDump) begin
         if (stageW.branchInst) begin
            modelPc = newPC;
         end else if (!expectBubble(raw)) begin
            modelPc = modelPc + 16'd2;
         end
      end
   endtask

   task automatic awaitEdge();
      @(negedge clk);
      checkOutputs();
   endtask

   task automatic applyInputs(input stageInfoT d, input stageInfoT x, input stageInfoT m,
                              input stageInfoT w, input logic dump, input addrT target);
      stageD     = d;
      stageX     = x;
      stageM     = m;
      stageW     = w;
      createDump = dump;
      newPC      = target;
      stepModel();
   endtask

   task automatic reportTest(input string name, input int cycles, input int errStart);
      $display("%s: %0d cycles, %0d errors", name, cycles, errors - errStart);
   endtask

   initial begin : mainFlow
      int   errStart;
      wordT heldInstr;
      addrT heldInc;
      addrT target;

      clk        = 1'b0;
      rstN       = 1'b0;
      createDump = 1'b0;
      newPC      = '0;
      stageD     = idle;
      stageX     = idle;
      stageM     = idle;
      stageW     = idle;
      progEn     = 1'b0;
      progAddr   = '0;
      progData   = '0;
      modelPc    = '0;
      checks     = 0;
      errors     = 0;
      void'($urandom(32'hbe3a));
      for (int i = 0; i < nWords; i++) begin
         prog[i] = nopInstr;   // Matches the memory's initial fill.
      end

      // Program load, one word per edge under reset.
      errStart = errors;
      for (int i = 0; i < nWords; i++) begin
         awaitEdge();
         progEn   = 1'b1;
         progAddr = addrT'(i) << 1;
         progData = wordT'($urandom);
         prog[i]  = progData;
         stepModel();
      end
      reportTest("program load", nWords, errStart);

      errStart = errors;
      awaitEdge();
      progEn = 1'b0;
      for (int i = 0; i < 3; i++) begin
         awaitEdge();
         checkFlag("instrValid", instrValid, 1'b0);
         checkFlag("branchInstF", branchInstF, 1'b0);
      end
      rstN = 1'b1;
      applyInputs(idle, idle, idle, idle, 1'b1, '0);   // Keep word 0 for one more cycle.
      awaitEdge();
      checkWord("instruction", instruction, prog[0]);
      checkFlag("instrValid", instrValid, 1'b1);
      applyInputs(idle, idle, idle, idle, 1'b0, '0);
      reportTest("reset", 5, errStart);

      errStart = errors;
      for (int i = 0; i < nSeq; i++) begin
         awaitEdge();
         applyInputs(idle, idle, idle, idle, 1'b0, '0);
      end
      reportTest("sequential fetch", nSeq, errStart);

      // Writers at D, X, M and W, no transfers.
      errStart = errors;
      for (int i = 0; i < nHazard; i++) begin
         awaitEdge();
         applyInputs(randomStage(40, 0), randomStage(40, 0), randomStage(40, 0),
                     randomStage(60, 0), 1'b0, '0);
      end
      reportTest("data hazard", nHazard, errStart);

      errStart = errors;
      for (int i = 0; i < nCtrl; i++) begin
         awaitEdge();
         applyInputs(randomStage(20, 8), randomStage(20, 8), randomStage(20, 8),
                     randomStage(20, 6), ($urandom % 100) < 5, randomEven());
      end
      awaitEdge();
      target = randomEven();
      applyInputs(idle, idle, idle, redirect, 1'b0, target);
      awaitEdge();
      checkWord("instruction", instruction, prog[target[memDepthLog2:1]]);
      applyInputs(idle, idle, idle, idle, 1'b0, '0);
      reportTest("control transfer", nCtrl + 2, errStart);

      // A redirect at W must not move a frozen PC either.
      errStart = errors;
      heldInstr = '0;
      heldInc   = '0;
      for (int i = 0; i < nDump; i++) begin
         awaitEdge();
         if (i == 0) begin
            heldInstr = prog[modelPc[memDepthLog2:1]];
            heldInc   = modelPc + 16'd2;
         end else begin
            checkWord("instruction", instruction, heldInstr);
            checkAddr("incPC", incPC, heldInc);
         end
         applyInputs(idle, idle, idle, randomStage(50, 50), 1'b1, randomEven());
      end
      awaitEdge();
      applyInputs(idle, idle, idle, idle, 1'b0, '0);
      reportTest("dump hold", nDump + 1, errStart);

      errStart = errors;
      awaitEdge();
      applyInputs(idle, idle, idle, redirect, 1'b0, 16'hfffe);
      awaitEdge();
      checkFlag("err", err, 1'b1);
      applyInputs(idle, idle, idle, idle, 1'b0, '0);
      awaitEdge();
      checkFlag("err", err, 1'b0);   // Incremented past FFFE to 0000.
      checkAddr("incPC", incPC, 16'h0002);
      applyInputs(idle, idle, idle, idle, 1'b0, '0);
      for (int i = 0; i < nWrap; i++) begin
         awaitEdge();
         applyInputs(idle, idle, idle, idle, 1'b0, '0);
      end
      awaitEdge();
      reportTest("wrap error", nWrap + 4, errStart);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src/fetchStage.sv
/*
   Fetch stage: PC register, +2 increment, instruction read and hazard bubbles.
   Next PC priority is dump hold, writeback redirect, bubble hold, then PC + 2.
   Outputs follow the bubble only; a redirect does not suppress the word
   fetched in the same cycle.
   newPC must be even. err flags the increment wrapping past FFFE.
*/
`timescale 1ns/100ps
`default_nettype none

module fetchStage import fetchPkg::*; (
   input  logic      clk,
   input  logic      rstN,
   input  logic      createDump,
   input  addrT      newPC,
   input  stageInfoT stageD,
   input  stageInfoT stageX,
   input  stageInfoT stageM,
   input  stageInfoT stageW,
   input  logic      progEn,
   input  addrT      progAddr,
   input  wordT      progData,
   output wordT      instruction,
   output addrT      incPC,
   output logic      instrValid,
   output logic      branchInstF,
   output logic      err
);

   addrT pc;
   addrT pcNext;
   wordT rawInstr;
   logic bubble;

   cla16 u_pcInc (
      .a    (pc),
      .b    (pcStep),
      .cIn  (1'b0),
      .sum  (incPC),
      .cOut (),
      .ofl  (err)        // Only set when pc is FFFE.
   );

   instrMem u_instrMem (
      .clk      (clk),
      .addr     (pc),
      .data     (rawInstr),
      .progEn   (progEn),
      .progAddr (progAddr),
      .progData (progData)
   );

   hazardDetect u_hazardDetect (
      .rawInstr    (rawInstr),
      .stageD      (stageD),
      .stageX      (stageX),
      .stageM      (stageM),
      .rstN        (rstN),
      .bubble      (bubble),
      .branchInstF (branchInstF)
   );

   // Next PC selection.
   always_comb begin
      if (createDump) begin
         pcNext = pc;                  // Frozen for the dump.
      end else if (stageW.branchInst) begin
         pcNext = newPC;               // Transfer resolved at writeback.
      end else if (bubble) begin
         pcNext = pc;
      end else begin
         pcNext = incPC;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else begin
         pc <= pcNext;
      end
   end

   assign instruction = bubble ? nopInstr : rawInstr;
   assign instrValid  = ~bubble;

   // A bubble without a redirect must leave the PC where it was.
   assert property (@(posedge clk) disable iff (!rstN)
      (bubble && !stageW.branchInst) |=> $stable(pc))
      else $error("fetchStage: PC moved after a bubble, now %h", pc);

   assert property (@(posedge clk) disable iff (!rstN) !pc[0])
      else $error("fetchStage: odd PC %h", pc);

endmodule

`default_nettype wire

// File: src/hazardDetect.sv
/*
   Hazard check for the fetched word.
   Only the opcode and the Rs/Rt fields are decoded here.
   Writeback is not checked since the register file writes before it reads.
   The redirect from writeback is handled by the caller, not here.
   bubble is also high while rstN is low.
*/
`timescale 1ns/100ps
`default_nettype none

module hazardDetect import fetchPkg::*; (
   input  wordT      rawInstr,
   input  stageInfoT stageD,
   input  stageInfoT stageX,
   input  stageInfoT stageM,
   input  logic      rstN,
   output logic      bubble,
   output logic      branchInstF
);

   opcodeT opcode;
   regIdT  rsId;
   regIdT  rtId;
   logic   readsRs;
   logic   readsRt;
   logic   isCtrl;
   logic   hitD;
   logic   hitX;
   logic   hitM;
   logic   dataHazard;
   logic   ctrlInFlight;

   // True when a stage will write a register that the fetched word reads.
   function automatic logic writerHit(
      input stageInfoT st,
      input regIdT     rs,
      input regIdT     rt,
      input logic      useRs,
      input logic      useRt
   );
      logic rsMatch;
      logic rtMatch;
      rsMatch = useRs && (st.wrtReg == rs);
      rtMatch = useRt && (st.wrtReg == rt);
      return st.regWrt && (rsMatch || rtMatch);
   endfunction

   assign opcode = rawInstr[opMsb:opLsb];
   assign rsId   = rawInstr[rsMsb:rsLsb];
   assign rtId   = rawInstr[rtMsb:rtLsb];

   // Halt, NOP and the plain jumps have no register source.
   assign readsRs = !(opcode inside {opHalt, opNop, opJ, opJal});

   // Two-source formats.
   assign readsRt = opcode inside {opAluRR, opCmp, opSt, opStu};

   assign isCtrl = (opcode[4:2] == ctrlJumpPrefix) || (opcode[4:2] == ctrlBranchPrefix);

   assign hitD = writerHit(stageD, rsId, rtId, readsRs, readsRt);
   assign hitX = writerHit(stageX, rsId, rtId, readsRs, readsRt);
   assign hitM = writerHit(stageM, rsId, rtId, readsRs, readsRt);

   assign dataHazard   = hitD | hitX | hitM;
   assign ctrlInFlight = stageD.branchInst | stageX.branchInst | stageM.branchInst;

   // No issue during reset, behind a transfer, or on a source conflict.
   assign bubble = !rstN | ctrlInFlight | dataHazard;

   assign branchInstF = isCtrl & ~bubble;   // Only an issued word is flagged.

endmodule

`default_nettype wire

// File: src/instrMem.sv
/*
   Word-addressed instruction memory, 2**memDepthLog2 words.
   Address bit 0 is ignored and higher bits above the depth alias.
   The read is combinational. The load port writes on the rising edge
   and is meant for program loading while the core is in reset.
   Words never loaded read as NOP.
*/
`timescale 1ns/100ps
`default_nettype none

module instrMem import fetchPkg::*; (
   input  logic clk,
   input  addrT addr,
   output wordT data,
   input  logic progEn,
   input  addrT progAddr,
   input  wordT progData
);

   wordT                    mem [2**memDepthLog2];
   logic [memDepthLog2-1:0] rdIdx;
   logic [memDepthLog2-1:0] wrIdx;

   assign rdIdx = addr[memDepthLog2:1];       // Byte address to word index.
   assign wrIdx = progAddr[memDepthLog2:1];

   // Empty memory executes as a run of NOPs.
   initial begin
      for (int i = 0; i < 2**memDepthLog2; i++) begin
         mem[i] = nopInstr;
      end
   end

   always_ff @(posedge clk) begin
      if (progEn) begin
         mem[wrIdx] <= progData;
      end
   end

   assign data = mem[rdIdx];

endmodule

`default_nettype wire

// File: src/cla16.sv
/*
   16-bit carry-lookahead adder, four 4-bit lookahead groups.
   ofl is the unsigned overflow, i.e. the carry out of bit 15.
   Signed overflow is not reported.
*/
`timescale 1ns/100ps
`default_nettype none

module cla16 import fetchPkg::*; (
   input  wordT a,
   input  wordT b,
   input  logic cIn,
   output wordT sum,
   output logic cOut,
   output logic ofl
);

   wordT       g;
   wordT       p;
   wordT       carry;     // Carry into each bit.
   logic [3:0] grpG;
   logic [3:0] grpP;
   logic [4:0] grpC;      // Carry into each group, plus final carry.

   assign g = a & b;
   assign p = a ^ b;

   for (genvar k = 0; k < 4; k++) begin : gGroup
      logic [3:0] gs;
      logic [3:0] ps;

      assign gs = g[4*k +: 4];
      assign ps = p[4*k +: 4];

      // Lookahead carries inside the group.
      assign carry[4*k]   = grpC[k];
      assign carry[4*k+1] = gs[0] | (ps[0] & grpC[k]);
      assign carry[4*k+2] = gs[1] | (ps[1] & gs[0]) | (ps[1] & ps[0] & grpC[k]);
      assign carry[4*k+3] = gs[2] | (ps[2] & gs[1]) | (ps[2] & ps[1] & gs[0])
                          | (ps[2] & ps[1] & ps[0] & grpC[k]);

      assign grpG[k] = gs[3] | (ps[3] & gs[2]) | (ps[3] & ps[2] & gs[1])
                     | (ps[3] & ps[2] & ps[1] & gs[0]);
      assign grpP[k] = &ps;
   end

   // Second level of lookahead across the groups.
   assign grpC[0] = cIn;
   assign grpC[1] = grpG[0] | (grpP[0] & cIn);
   assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & cIn);
   assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                  | (grpP[2] & grpP[1] & grpP[0] & cIn);
   assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                  | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                  | (grpP[3] & grpP[2] & grpP[1] & grpP[0] & cIn);

   assign sum  = p ^ carry;
   assign cOut = grpC[4];
   assign ofl  = grpC[4];   // Unsigned operands, so overflow is the carry out.

   // Lookahead network against a plain add.
   always_comb begin
      assert final ({cOut, sum} == ({1'b0, a} + {1'b0, b} + {16'd0, cIn}))
         else $error("cla16: %h + %h + %b gave %b_%h", a, b, cIn, cOut, sum);
   end

endmodule

`default_nettype wire

// File: src/fetchPkg.sv
/*
   Shared types and constants for the fetch stage of the 16-bit pipeline.
   Opcode and register field positions follow the teaching ISA encoding.
   Only the fields that fetch needs are described here.
*/
`default_nettype none

package fetchPkg;

   typedef logic [15:0] wordT;   // Instruction or data word.
   typedef logic [15:0] addrT;   // Byte address.
   typedef logic [2:0]  regIdT;
   typedef logic [4:0]  opcodeT;

   // Instruction field positions.
   localparam int opMsb = 15;
   localparam int opLsb = 11;
   localparam int rsMsb = 10;
   localparam int rsLsb = 8;
   localparam int rtMsb = 7;
   localparam int rtLsb = 5;

   localparam int memDepthLog2 = 10;        // 1024 words.
   localparam addrT pcStep = 16'd2;

   localparam opcodeT opHalt  = 5'b00000;
   localparam opcodeT opNop   = 5'b00001;
   localparam opcodeT opJ     = 5'b00100;
   localparam opcodeT opJal   = 5'b00110;
   localparam opcodeT opAluRR = 5'b11011;
   localparam opcodeT opCmp   = 5'b11111;
   localparam opcodeT opSt    = 5'b10000;
   localparam opcodeT opStu   = 5'b10011;

   localparam wordT nopInstr = 16'h0800;

   // Top three opcode bits of jumps and branches.
   localparam logic [2:0] ctrlJumpPrefix   = 3'b001;
   localparam logic [2:0] ctrlBranchPrefix = 3'b011;

   // What one later stage holds in the current cycle.
   typedef struct packed {
      logic  regWrt;
      regIdT wrtReg;
      logic  branchInst;
   } stageInfoT;

endpackage

`default_nettype wire
